//--- bench/vlvtype_checker.sv
`default_nettype none

module vlvtype_checker #(
  parameter int REN_SIZE = 8
) (
  input logic                i_clk,
  input logic                i_reset_n,
  input logic                i_issue_valid,
  input logic                i_commit_valid,
  input logic                i_commit_ready,
  input logic                i_credit_return,
  input logic [REN_SIZE-1:0] i_table_valid
);
  timeunit 1ns;
  timeprecision 100ps;

  // ----------------------------------------------------------------------
  // credit return
  // ----------------------------------------------------------------------
  credit_after_commit: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_commit_valid |=> i_credit_return)
    else $error("no credit pulse in the cycle after a commit");

  credit_needs_commit: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_credit_return |-> $past(i_commit_valid))
    else $error("credit pulse without a commit one cycle earlier");

  // ----------------------------------------------------------------------
  // committer and issuer protocol
  // ----------------------------------------------------------------------
  commit_when_ready: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_commit_valid |-> i_commit_ready)
    else $error("commit asserted while the oldest slot is not ready");

  // full table means the issuer ran past its credits
  no_issue_when_full: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_issue_valid |-> !(&i_table_valid))
    else $error("issue accepted while every slot is valid");

endmodule

bind vlvtype_rename_table vlvtype_checker #(
  .REN_SIZE (REN_SIZE)
) u_checker (
  .i_clk           (i_clk),
  .i_reset_n       (i_reset_n),
  .i_issue_valid   (i_issue_valid),
  .i_commit_valid  (i_commit_valid),
  .i_commit_ready  (o_commit_ready),
  .i_credit_return (o_credit_return),
  .i_table_valid   (table_valid)
);

`default_nettype wire

//--- bench/vlvtype_tb.sv
`default_nettype none

module vlvtype_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int         REN_SIZE = 8;
  localparam int         VLEN     = 128;
  localparam int         IDX_W    = 3;
  localparam int         TIMEOUT  = 50;
  localparam logic [6:0] OP_V     = 7'h57;

  typedef struct packed {
    logic                           valid;
    logic [IDX_W-1:0]               index;
    vlvtype_ren_pkg::ren_upd_body_t vlvtype;
  } done_t;

  // one instruction in flight, waiting for o_done
  typedef struct packed {
    logic [IDX_W-1:0]      index;
    vec_cfg_pkg::vlvtype_t value;
    int                    due_cycle;
  } pend_t;

  logic                        clk;
  logic                        reset_n;
  vlvtype_ren_pkg::ren_issue_t issue;
  logic [IDX_W-1:0]            issue_index;
  logic                        credit_return;
  logic                        commit_valid;
  logic                        commit_ready;
  logic [IDX_W-1:0]            rd_index;
  vec_cfg_pkg::vlvtype_t       rd_vlvtype;
  done_t                       done;
  vec_cfg_pkg::vlvtype_t       arch_vlvtype;

  int                    credits;
  int                    cycles = 0;
  string                 test_name;
  vec_cfg_pkg::vlvtype_t commit_q [$];
  pend_t                 pend_q [$];
  vec_cfg_pkg::vlvtype_t slot_model [REN_SIZE];
  logic [REN_SIZE-1:0]   slot_live;
  logic [IDX_W-1:0]      arch_slot;
  // next slot the table should allocate
  logic [IDX_W-1:0]      head_slot;

  vlvtype_rename_top #(
    .REN_SIZE (REN_SIZE),
    .VLEN     (VLEN)
  ) dut (
    .i_clk           (clk),
    .i_reset_n       (reset_n),
    .i_issue         (issue),
    .o_issue_index   (issue_index),
    .o_credit_return (credit_return),
    .i_commit_valid  (commit_valid),
    .o_commit_ready  (commit_ready),
    .i_rd_index      (rd_index),
    .o_rd_vlvtype    (rd_vlvtype),
    .o_done          (done),
    .o_arch_vlvtype  (arch_vlvtype)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  always @(posedge clk) cycles <= cycles + 1;

  // ----------------------------------------------------------------------
  // failure reporting
  // ----------------------------------------------------------------------
  task automatic abort_run();
    $display("STATUS: FAIL");
    $fatal(1, "testbench stopped at the first failure");
  endtask

  task automatic check_eq(input string what, input logic [31:0] expected,
                          input logic [31:0] actual);
    assert (expected === actual) else begin
      $display("[ERROR] %s: %s expected 0x%0h actual 0x%0h", test_name, what,
               expected, actual);
      abort_run();
    end
  endtask

  task automatic report_failure(input string msg);
    $display("[ERROR] %s: %s", test_name, msg);
    abort_run();
  endtask

  // ----------------------------------------------------------------------
  // reference model
  // ----------------------------------------------------------------------
  // vtype_bits is vma, vta, sew, lmul as in the zimm field
  function automatic vec_cfg_pkg::vlvtype_t expect_vlvtype(input logic [2:0]  rsv,
                                                           input logic [7:0]  vtype_bits,
                                                           input logic [15:0] avl,
                                                           input logic        want_vlmax);
    vec_cfg_pkg::vlvtype_t r;
    logic [2:0]            sew;
    logic [2:0]            lmul;
    int                    vlmax;
    sew  = vtype_bits[5:3];
    lmul = vtype_bits[2:0];
    r    = '0;
    if (rsv != 3'd0 || sew > 3'd3 || lmul > 3'd3) begin
      r.vtype.vill = 1'b1;
    end else begin
      vlmax        = (VLEN << lmul) / (8 << sew);
      r.vtype.vma  = vtype_bits[7];
      r.vtype.vta  = vtype_bits[6];
      r.vtype.sew  = sew;
      r.vtype.lmul = lmul;
      if (want_vlmax || int'(avl) > vlmax) begin
        r.vl = 16'(vlmax);
      end else begin
        r.vl = avl;
      end
    end
    return r;
  endfunction

  function automatic logic [31:0] vsetvli_word(input logic [4:0] rd, input logic [4:0] rs1,
                                               input logic [10:0] zimm);
    return {1'b0, zimm, rs1, 3'b111, rd, OP_V};
  endfunction

  function automatic logic [31:0] vsetivli_word(input logic [4:0] rd, input logic [4:0] uimm,
                                                input logic [9:0] zimm);
    return {2'b11, zimm, uimm, 3'b111, rd, OP_V};
  endfunction

  // ----------------------------------------------------------------------
  // issue, commit, read
  // ----------------------------------------------------------------------
  task automatic issue_insn(input logic [31:0] word, input logic [15:0] rs1_val,
                            input vec_cfg_pkg::vlvtype_t expected);
    pend_t p;
    if (credits == 0) begin
      report_failure("issue attempted with no credit left");
    end
    check_eq("o_issue_index", 32'(head_slot), 32'(issue_index));
    issue.valid   = 1'b1;
    issue.insn    = word;
    issue.rs1_val = rs1_val;
    p.index       = head_slot;
    p.value       = expected;
    @(posedge clk);
    #1;
    issue.valid = 1'b0;
    p.due_cycle = cycles + 1;
    head_slot   = IDX_W'(head_slot + 1);
    credits--;
    pend_q.push_back(p);
    commit_q.push_back(expected);
    slot_model[p.index] = expected;
    slot_live[p.index]  = 1'b1;
  endtask

  task automatic issue_random_legal();
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [15:0] avl;
    logic [7:0]  vt;
    rd  = 5'($urandom_range(31, 0));
    rs1 = 5'($urandom_range(31, 1));
    avl = 16'($urandom_range(300, 0));
    vt  = {2'($urandom_range(3, 0)), 3'($urandom_range(3, 0)), 3'($urandom_range(3, 0))};
    issue_insn(vsetvli_word(rd, rs1, {3'b000, vt}), avl,
               expect_vlvtype(3'b000, vt, avl, 1'b0));
  endtask

  task automatic commit_one();
    vec_cfg_pkg::vlvtype_t expected;
    int                    wait_cnt;
    wait_cnt = 0;
    if (commit_q.size() == 0) begin
      report_failure("commit requested with nothing allocated");
    end
    while (!commit_ready && wait_cnt < TIMEOUT) begin
      @(posedge clk);
      #1;
      wait_cnt++;
    end
    if (!commit_ready) begin
      report_failure("timed out waiting for o_commit_ready");
    end
    expected     = commit_q.pop_front();
    commit_valid = 1'b1;
    @(posedge clk);
    #1;
    commit_valid = 1'b0;
    check_eq("o_arch_vlvtype", 32'(expected), 32'(arch_vlvtype));
    check_eq("o_credit_return", 32'd1, 32'(credit_return));
    // previous architectural slot is freed
    slot_live[arch_slot] = 1'b0;
    arch_slot            = IDX_W'(arch_slot + 1);
  endtask

  task automatic drain_pipeline();
    int wait_cnt;
    wait_cnt = 0;
    while (pend_q.size() != 0 && wait_cnt < TIMEOUT) begin
      @(posedge clk);
      #1;
      wait_cnt++;
    end
    if (pend_q.size() != 0) begin
      report_failure("timed out waiting for o_done");
    end
    // table write lands one edge after o_done
    @(posedge clk);
    #1;
  endtask

  task automatic check_reads(input int count);
    logic [IDX_W-1:0] idx;
    for (int n = 0; n < count; n++) begin
      idx = IDX_W'($urandom_range(REN_SIZE - 1, 0));
      if (slot_live[idx]) begin
        rd_index = idx;
        @(posedge clk);
        #1;
        check_eq($sformatf("o_rd_vlvtype slot %0d", idx), 32'(slot_model[idx]),
                 32'(rd_vlvtype));
      end
    end
  endtask

  // ----------------------------------------------------------------------
  // o_done and credit monitor, sampled mid-cycle
  // ----------------------------------------------------------------------
  always begin : done_monitor
    pend_t head;
    @(posedge clk);
    #2;
    if (credit_return) begin
      credits++;
    end
    if (done.valid) begin
      if (pend_q.size() == 0) begin
        report_failure("o_done pulsed with no instruction in flight");
      end
      head = pend_q.pop_front();
      check_eq("o_done index", 32'(head.index), 32'(done.index));
      check_eq("o_done vlvtype", 32'(head.value), 32'(done.vlvtype));
      check_eq("o_done cycle", 32'(head.due_cycle), 32'(cycles));
    end else if (pend_q.size() != 0 && pend_q[0].due_cycle <= cycles) begin
      report_failure("o_done missing two cycles after issue");
    end
  end

  // ----------------------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------------------
  initial begin : stimulus
    vec_cfg_pkg::vlvtype_t reset_val;
    logic [7:0]            vt;
    void'($urandom(99249));
    reset_n      = 1'b0;
    issue        = '0;
    commit_valid = 1'b0;
    rd_index     = '0;
    credits      = REN_SIZE - 1;
    slot_live    = '0;
    slot_live[0] = 1'b1;
    arch_slot    = '0;
    head_slot    = IDX_W'(1);
    reset_val              = '0;
    reset_val.vtype.vill   = 1'b1;
    slot_model             = '{default: '0};
    slot_model[0]          = reset_val;
    repeat (10) @(posedge clk);
    #1;
    reset_n = 1'b1;
    @(posedge clk);
    #1;

    test_name = "reset";
    check_eq("o_arch_vlvtype", 32'(reset_val), 32'(arch_vlvtype));
    check_eq("o_rd_vlvtype slot 0", 32'(reset_val), 32'(rd_vlvtype));
    check_eq("o_credit_return", 32'd0, 32'(credit_return));
    check_eq("o_done valid", 32'd0, 32'(done.valid));
    check_eq("o_commit_ready", 32'd0, 32'(commit_ready));

    // seven issues use up every credit
    test_name = "arithmetic";
    issue_random_legal();
    issue_random_legal();

    test_name = "vsetivli uimm";
    vt = {2'($urandom_range(3, 0)), 3'($urandom_range(3, 0)), 3'($urandom_range(3, 0))};
    issue_insn(vsetivli_word(5'd7, 5'd19, {2'b00, vt}), 16'($urandom_range(65535, 0)),
               expect_vlvtype(3'b000, vt, 16'd19, 1'b0));

    test_name = "vlmax request";
    vt = {2'b01, 3'd1, 3'd2};
    issue_insn(vsetvli_word(5'd3, 5'd0, {3'b000, vt}), 16'd4,
               expect_vlvtype(3'b000, vt, 16'd4, 1'b1));

    test_name = "illegal vtype";
    vt = {2'b00, 3'd5, 3'd0};
    issue_insn(vsetvli_word(5'd1, 5'd2, {3'b000, vt}), 16'd10,
               expect_vlvtype(3'b000, vt, 16'd10, 1'b0));
    vt = {2'b00, 3'd0, 3'd4};
    issue_insn(vsetvli_word(5'd1, 5'd2, {3'b000, vt}), 16'd10,
               expect_vlvtype(3'b000, vt, 16'd10, 1'b0));
    vt = {2'b00, 3'd1, 3'd1};
    issue_insn(vsetvli_word(5'd1, 5'd2, {3'b010, vt}), 16'd10,
               expect_vlvtype(3'b010, vt, 16'd10, 1'b0));

    drain_pipeline();
    test_name = "read port";
    check_reads(12);

    test_name = "credits";
    check_eq("credit count", 32'd0, 32'(credits));
    while (commit_q.size() != 0) begin
      commit_one();
    end
    drain_pipeline();
    check_eq("credit count", 32'(REN_SIZE - 1), 32'(credits));

    // head now restarts at slot 0
    test_name = "wrap";
    repeat (REN_SIZE - 1) issue_random_legal();
    drain_pipeline();
    check_reads(12);
    while (commit_q.size() != 0) begin
      commit_one();
    end

    test_name = "mixed";
    for (int n = 0; n < 30; n++) begin
      if (credits > 0 && $urandom_range(1, 0) == 1) begin
        issue_random_legal();
      end else if (commit_q.size() != 0) begin
        commit_one();
      end else begin
        @(posedge clk);
        #1;
      end
    end
    drain_pipeline();
    check_reads(8);
    while (commit_q.size() != 0) begin
      commit_one();
    end
    drain_pipeline();
    check_eq("credit count", 32'(REN_SIZE - 1), 32'(credits));

    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# build the vl/vtype rename testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --timescale 1ns/100ps \
  --top-module vlvtype_tb \
  -f vlvtype_rename.f \
  --Mdir obj_dir \
  -o vlvtype_sim

./obj_dir/vlvtype_sim

//--- source/vec_cfg_pkg.sv
`default_nettype none

package vec_cfg_pkg;

  // ----------------------------------------------------------------------
  // vl / vtype fields
  // ----------------------------------------------------------------------
  localparam int XLEN_VL = 16;

  // element width, 0..3 map to 8..64 bits
  typedef logic [2:0] sew_t;
  // register grouping, negative codes are fractional
  typedef logic signed [2:0] lmul_t;

  localparam sew_t SEW_MAX = 3'd3;

  typedef struct packed {
    logic  vill;
    logic  vma;
    logic  vta;
    sew_t  sew;
    lmul_t lmul;
  } vtype_t;

  // one rename table entry
  typedef struct packed {
    logic [XLEN_VL-1:0] vl;
    vtype_t             vtype;
  } vlvtype_t;

  // architectural value after reset, also used for illegal results
  localparam vlvtype_t VLVTYPE_RESET = '{
    vl:    '0,
    vtype: '{vill: 1'b1, vma: 1'b0, vta: 1'b0, sew: '0, lmul: '0}
  };

  // ----------------------------------------------------------------------
  // instruction word views
  // ----------------------------------------------------------------------
  localparam logic [1:0] VSETIVLI_TOP = 2'b11;

  typedef struct packed {
    logic        top;
    logic [10:0] zimm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } vsetvli_view_t;

  typedef struct packed {
    logic [1:0] top;
    logic [9:0] zimm;
    logic [4:0] uimm;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } vsetivli_view_t;

  // top bits pick the view
  typedef union packed {
    vsetvli_view_t  vli;
    vsetivli_view_t vili;
  } vsetvl_insn_u;

endpackage

`default_nettype wire

//--- source/vl_calc_unit.sv
`default_nettype none

module vl_calc_unit #(
  parameter int  REN_IDX_W = 3,
  parameter int  VLEN      = 128,
  parameter type ren_dec_t = struct packed {
    logic                          valid;
    logic [REN_IDX_W-1:0]          index;
    vlvtype_ren_pkg::ren_dec_body_t body;
  },
  parameter type ren_upd_t = struct packed {
    logic                          valid;
    logic [REN_IDX_W-1:0]          index;
    vlvtype_ren_pkg::ren_upd_body_t vlvtype;
  }
) (
  input  logic     i_clk,
  input  logic     i_reset_n,
  input  ren_dec_t i_dec,
  output ren_upd_t o_upd
);

  localparam int              VL_W       = vec_cfg_pkg::XLEN_VL;
  localparam logic [VL_W-1:0] VLEN_BYTES = VL_W'(VLEN / 8);

  vec_cfg_pkg::vtype_t            vt;
  logic                           legal;
  logic [VL_W-1:0]                vlmax;
  vlvtype_ren_pkg::ren_upd_body_t result;

  logic                           valid_q;
  logic [REN_IDX_W-1:0]           index_q;
  vlvtype_ren_pkg::ren_upd_body_t result_q;

  // ----------------------------------------------------------------------
  // legality and vl
  // ----------------------------------------------------------------------
  always_comb begin
    vt = i_dec.body.vtype;
    // lmul bit 2 set covers both fractional and reserved codes
    legal = !vt.vill && (vt.sew <= vec_cfg_pkg::SEW_MAX) && !vt.lmul[2];

    // VLEN * LMUL / SEW, SEW counted in bytes
    vlmax = (VLEN_BYTES << vt.lmul[1:0]) >> vt.sew[1:0];

    if (!legal) begin
      result = vec_cfg_pkg::VLVTYPE_RESET;
    end else begin
      result.vtype = vt;
      if (i_dec.body.avl_is_vlmax || (i_dec.body.avl > vlmax)) begin
        result.vl = vlmax;
      end else begin
        result.vl = i_dec.body.avl;
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= i_dec.valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_dec.valid) begin
      index_q  <= i_dec.index;
      result_q <= result;
    end
  end

  assign o_upd.valid   = valid_q;
  assign o_upd.index   = index_q;
  assign o_upd.vlvtype = result_q;

endmodule

`default_nettype wire

//--- source/vlvtype_ren_pkg.sv
`default_nettype none

package vlvtype_ren_pkg;

  // ----------------------------------------------------------------------
  // rename transport payloads
  // ----------------------------------------------------------------------
  // index fields depend on the table size, so the valid/index wrappers
  // are built in each module around the bodies below

  // issue request from the front end
  typedef struct packed {
    logic                               valid;
    vec_cfg_pkg::vsetvl_insn_u          insn;
    logic [vec_cfg_pkg::XLEN_VL-1:0]    rs1_val;
  } ren_issue_t;

  // decoded request, before vl is known
  typedef struct packed {
    logic [vec_cfg_pkg::XLEN_VL-1:0] avl;
    vec_cfg_pkg::vtype_t             vtype;
    // rs1 is x0 and rd is not x0
    logic                            avl_is_vlmax;
  } ren_dec_body_t;

  // update and read payload, kept as its own name for the transport side
  typedef vec_cfg_pkg::vlvtype_t ren_upd_body_t;

  // commit side state as seen by the committer
  typedef struct packed {
    logic ready;
    logic credit;
  } ren_cmt_status_t;

endpackage

`default_nettype wire

//--- source/vlvtype_rename_table.sv
`default_nettype none

module vlvtype_rename_table #(
  parameter int  REN_SIZE  = 8,
  parameter int  REN_IDX_W = $clog2(REN_SIZE),
  parameter type ren_upd_t = struct packed {
    logic                          valid;
    logic [REN_IDX_W-1:0]          index;
    vlvtype_ren_pkg::ren_upd_body_t vlvtype;
  }
) (
  input  logic                  i_clk,
  input  logic                  i_reset_n,

  input  logic                  i_issue_valid,
  output logic [REN_IDX_W-1:0]  o_issue_index,

  input  ren_upd_t              i_upd,

  input  logic                  i_commit_valid,
  output logic                  o_commit_ready,
  output logic                  o_credit_return,
  output vec_cfg_pkg::vlvtype_t o_arch_vlvtype,

  input  logic [REN_IDX_W-1:0]  i_rd_index,
  output vec_cfg_pkg::vlvtype_t o_rd_vlvtype
);

  typedef logic [REN_SIZE-1:0] slot_vec_t;

  vec_cfg_pkg::vlvtype_t             table_q [REN_SIZE];
  slot_vec_t                         table_valid;
  slot_vec_t                         table_ready;

  logic [REN_IDX_W-1:0]              head_ptr;
  // slot that holds the current architectural value
  logic [REN_IDX_W-1:0]              cmt_ptr;
  logic [REN_IDX_W-1:0]              cmt_next;

  vec_cfg_pkg::vlvtype_t             arch_q;
  vlvtype_ren_pkg::ren_cmt_status_t  cmt_status;

  assign cmt_next = cmt_ptr + 1'b1;

  // ----------------------------------------------------------------------
  // pointers
  // ----------------------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      head_ptr <= REN_IDX_W'(1);
      cmt_ptr  <= '0;
    end else begin
      if (i_issue_valid) begin
        head_ptr <= head_ptr + 1'b1;
      end
      if (i_commit_valid) begin
        cmt_ptr <= cmt_next;
      end
    end
  end

  // ----------------------------------------------------------------------
  // slot state
  // ----------------------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      table_valid <= slot_vec_t'(1);
      table_ready <= slot_vec_t'(1);
    end else begin
      // old architectural slot is released on commit
      if (i_commit_valid) begin
        table_valid[cmt_ptr] <= 1'b0;
        table_ready[cmt_ptr] <= 1'b0;
      end
      if (i_issue_valid) begin
        table_valid[head_ptr] <= 1'b1;
        table_ready[head_ptr] <= 1'b0;
      end
      if (i_upd.valid) begin
        table_ready[i_upd.index] <= 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      table_q <= '{default: vec_cfg_pkg::VLVTYPE_RESET};
    end else if (i_upd.valid) begin
      table_q[i_upd.index] <= i_upd.vlvtype;
    end
  end

  // ----------------------------------------------------------------------
  // commit and credits
  // ----------------------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      arch_q            <= vec_cfg_pkg::VLVTYPE_RESET;
      cmt_status.credit <= 1'b0;
    end else begin
      cmt_status.credit <= i_commit_valid;
      if (i_commit_valid) begin
        arch_q <= table_q[cmt_next];
      end
    end
  end

  // next slot must be allocated and written
  assign cmt_status.ready = table_valid[cmt_next] & table_ready[cmt_next];

  assign o_issue_index   = head_ptr;
  assign o_commit_ready  = cmt_status.ready;
  assign o_credit_return = cmt_status.credit;
  assign o_arch_vlvtype  = arch_q;
  assign o_rd_vlvtype    = table_q[i_rd_index];

endmodule

`default_nettype wire

//--- source/vlvtype_rename_top.sv
`default_nettype none

module vlvtype_rename_top #(
  parameter int  REN_SIZE  = 8,
  parameter int  VLEN      = 128,
  parameter int  REN_IDX_W = $clog2(REN_SIZE),
  parameter type ren_dec_t = struct packed {
    logic                          valid;
    logic [REN_IDX_W-1:0]          index;
    vlvtype_ren_pkg::ren_dec_body_t body;
  },
  parameter type ren_upd_t = struct packed {
    logic                          valid;
    logic [REN_IDX_W-1:0]          index;
    vlvtype_ren_pkg::ren_upd_body_t vlvtype;
  }
) (
  input  logic                        i_clk,
  input  logic                        i_reset_n,
  input  vlvtype_ren_pkg::ren_issue_t i_issue,
  output logic [REN_IDX_W-1:0]        o_issue_index,
  output logic                        o_credit_return,
  input  logic                        i_commit_valid,
  output logic                        o_commit_ready,
  input  logic [REN_IDX_W-1:0]        i_rd_index,
  output vec_cfg_pkg::vlvtype_t       o_rd_vlvtype,
  output ren_upd_t                    o_done,
  output vec_cfg_pkg::vlvtype_t       o_arch_vlvtype
);

  ren_dec_t dec;
  ren_upd_t upd;

  // ----------------------------------------------------------------------
  // issue -> decode -> vl -> table write
  // ----------------------------------------------------------------------
  vsetvl_decoder #(
    .REN_IDX_W (REN_IDX_W),
    .ren_dec_t (ren_dec_t)
  ) u_decoder (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_issue   (i_issue),
    .i_index   (o_issue_index),
    .o_dec     (dec)
  );

  vl_calc_unit #(
    .REN_IDX_W (REN_IDX_W),
    .VLEN      (VLEN),
    .ren_dec_t (ren_dec_t),
    .ren_upd_t (ren_upd_t)
  ) u_calc (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_dec     (dec),
    .o_upd     (upd)
  );

  vlvtype_rename_table #(
    .REN_SIZE  (REN_SIZE),
    .REN_IDX_W (REN_IDX_W),
    .ren_upd_t (ren_upd_t)
  ) u_table (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_issue_valid   (i_issue.valid),
    .o_issue_index   (o_issue_index),
    .i_upd           (upd),
    .i_commit_valid  (i_commit_valid),
    .o_commit_ready  (o_commit_ready),
    .o_credit_return (o_credit_return),
    .o_arch_vlvtype  (o_arch_vlvtype),
    .i_rd_index      (i_rd_index),
    .o_rd_vlvtype    (o_rd_vlvtype)
  );

  assign o_done = upd;

endmodule

`default_nettype wire

//--- source/vsetvl_decoder.sv
`default_nettype none

module vsetvl_decoder #(
  parameter int  REN_IDX_W = 3,
  parameter type ren_dec_t = struct packed {
    logic                          valid;
    logic [REN_IDX_W-1:0]          index;
    vlvtype_ren_pkg::ren_dec_body_t body;
  }
) (
  input  logic                        i_clk,
  input  logic                        i_reset_n,
  input  vlvtype_ren_pkg::ren_issue_t i_issue,
  input  logic [REN_IDX_W-1:0]        i_index,
  output ren_dec_t                    o_dec
);

  localparam int VL_W = vec_cfg_pkg::XLEN_VL;

  vec_cfg_pkg::vsetvl_insn_u      insn;
  logic                           is_ivli;
  logic [10:0]                    zimm;
  vlvtype_ren_pkg::ren_dec_body_t dec_body;

  logic                           valid_q;
  logic [REN_IDX_W-1:0]           index_q;
  vlvtype_ren_pkg::ren_dec_body_t body_q;

  assign insn    = i_issue.insn;
  assign is_ivli = (insn.vili.top == vec_cfg_pkg::VSETIVLI_TOP);

  // ----------------------------------------------------------------------
  // field extraction
  // ----------------------------------------------------------------------
  always_comb begin
    if (is_ivli) begin
      dec_body.avl = VL_W'(insn.vili.uimm);
      zimm         = {1'b0, insn.vili.zimm};
    end else begin
      dec_body.avl = i_issue.rs1_val;
      zimm         = insn.vli.zimm;
    end
    dec_body.avl_is_vlmax = !is_ivli && (insn.vli.rs1 == 5'd0) && (insn.vli.rd != 5'd0);

    // reserved zimm bits ride along in vill until the legality check
    dec_body.vtype.vill = |zimm[10:8];
    dec_body.vtype.vma  = zimm[7];
    dec_body.vtype.vta  = zimm[6];
    dec_body.vtype.sew  = zimm[5:3];
    dec_body.vtype.lmul = zimm[2:0];
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= i_issue.valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_issue.valid) begin
      index_q <= i_index;
      body_q  <= dec_body;
    end
  end

  assign o_dec.valid = valid_q;
  assign o_dec.index = index_q;
  assign o_dec.body  = body_q;

endmodule

`default_nettype wire

//--- vlvtype_rename.f
source/vec_cfg_pkg.sv
source/vlvtype_ren_pkg.sv
source/vsetvl_decoder.sv
source/vl_calc_unit.sv
source/vlvtype_rename_table.sv
source/vlvtype_rename_top.sv
bench/vlvtype_checker.sv
bench/vlvtype_tb.sv
